//--- build.f
src/ldp_pkg.sv
src/ldp_ring_addr.sv
src/ldp_md_buffer.sv
src/ldp_beat_counter.sv
src/ldp_aw_sequencer.sv
src/ldp_w_sequencer.sv
src/ldp_manager.sv
verification/ldp_props.sv
verification/ldp_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the frame logger regression with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f build.f --top-module ldp_tb -o ldp_sim

sim_out=$(./obj_dir/ldp_sim)
echo "$sim_out"

if grep -qx "Regression passed" <<< "$sim_out"; then
    exit 0
fi
exit 1

//--- src/ldp_aw_sequencer.sv
// AW channel request sequencer
`timescale 1ns/1ps

module ldp_aw_sequencer #(
    parameter int burst_beats = 8
) (
    input  logic                          clk,
    input  logic                          resetn,
    input  ldp_pkg::ldp_cfg_t             cfg,
    input  logic [31:0]                   frames_started,
    input  logic [ldp_pkg::addr_w-1:0]    fd_addr,
    input  logic [ldp_pkg::addr_w-1:0]    md0_addr,
    input  logic [ldp_pkg::addr_w-1:0]    md1_addr,
    input  logic                          aw_ready,
    output ldp_pkg::aw_req_t              aw,
    output logic                          aw_valid,
    output logic                          fd_step,
    output logic                          md_step
);

    typedef enum logic [2:0] {
        AW_FD_FIRST,
        AW_FD_REST,
        AW_MD0,
        AW_MD1,
        AW_FC
    } aw_state_t;

    aw_state_t   state;
    logic [31:0] frames_issued;
    logic [31:0] bursts_issued;
    logic        aw_hs;

    assign aw_hs = aw_valid && aw_ready;

    // ============================================================
    // Request payload per state
    // ============================================================
    always_comb begin
        aw.addr  = fd_addr;
        aw.len   = 8'(burst_beats - 1);
        aw_valid = 1'b1;
        case (state)
            // Held back until W has started a frame we have not yet issued
            AW_FD_FIRST: aw_valid = (frames_started > frames_issued);
            AW_FD_REST:  aw_valid = 1'b1;
            AW_MD0: begin
                aw.addr = md0_addr;
                aw.len  = 8'(ldp_pkg::md_beats - 1);
            end
            AW_MD1: begin
                aw.addr = md1_addr;
                aw.len  = 8'(ldp_pkg::md_beats - 1);
            end
            AW_FC: begin
                aw.addr = cfg.fc_addr;
                aw.len  = 8'd0;
            end
            default: aw_valid = 1'b0;
        endcase
    end

    // Ring pointers move on accepted requests only
    assign fd_step = aw_hs && (state == AW_FD_FIRST || state == AW_FD_REST);
    assign md_step = aw_hs && (state == AW_FC);

    // ============================================================
    // State transitions
    // ============================================================
    always_ff @(posedge clk) begin
        if (!resetn) begin
            state         <= AW_FD_FIRST;
            frames_issued <= '0;
            bursts_issued <= '0;
        end else if (aw_hs) begin
            case (state)
                AW_FD_FIRST: begin
                    frames_issued <= frames_issued + 32'd1;
                    bursts_issued <= 32'd1;
                    // A one-burst frame goes straight to metadata
                    state <= (cfg.frame_bursts > 32'd1) ? AW_FD_REST : AW_MD0;
                end
                AW_FD_REST: begin
                    bursts_issued <= bursts_issued + 32'd1;
                    if (bursts_issued + 32'd1 >= cfg.frame_bursts) state <= AW_MD0;
                end
                AW_MD0:  state <= AW_MD1;
                AW_MD1:  state <= AW_FC;
                default: state <= AW_FD_FIRST;
            endcase
        end
    end

endmodule

//--- src/ldp_beat_counter.sv
// Frame-data beat and burst counter
`timescale 1ns/1ps

module ldp_beat_counter #(
    parameter int burst_beats = 8
) (
    input  logic        clk,
    input  logic        resetn,
    input  logic [31:0] frame_bursts,
    input  logic        beat_take,
    output logic        burst_end,
    output logic        frame_end
);

    localparam int beat_w = $clog2(burst_beats + 1);

    logic [beat_w-1:0] beat_cnt;
    logic [31:0]       burst_cnt;

    // These flag the beat now on offer, taken or not, so last is valid early
    assign burst_end = (beat_cnt == beat_w'(burst_beats - 1));
    assign frame_end = burst_end && (burst_cnt == frame_bursts - 32'd1);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            beat_cnt  <= '0;
            burst_cnt <= '0;
        end else if (beat_take) begin
            if (burst_end) begin
                beat_cnt <= '0;
                // Burst count restarts with each new frame
                if (frame_end) burst_cnt <= '0;
                else           burst_cnt <= burst_cnt + 32'd1;
            end else begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

endmodule

//--- src/ldp_manager.sv
// Frame logger top level
`timescale 1ns/1ps

module ldp_manager #(
    parameter int burst_beats      = 8,
    parameter int bursts_per_group = 4
) (
    input  logic                          clk,
    input  logic                          resetn,
    input  ldp_pkg::ldp_cfg_t             cfg,

    // Frame-data stream
    input  logic [ldp_pkg::data_w-1:0]    fd_data,
    input  logic                          fd_valid,
    output logic                          fd_ready,

    // Metadata stream
    input  logic [ldp_pkg::data_w-1:0]    md_data,
    input  logic                          md_valid,
    output logic                          md_ready,

    // Write address channel
    output ldp_pkg::aw_req_t              aw,
    output logic                          aw_valid,
    input  logic                          aw_ready,

    // Write data channel
    output ldp_pkg::w_beat_t              w,
    output logic                          w_valid,
    input  logic                          w_ready
);

    // ============================================================
    // Internal wiring
    // ============================================================
    logic                       fd_step;
    logic                       md_step;
    logic [ldp_pkg::addr_w-1:0] fd_addr;
    logic [ldp_pkg::addr_w-1:0] md0_addr;
    logic [ldp_pkg::addr_w-1:0] md1_addr;
    logic                       frame_start;
    logic                       beat_take;
    logic                       burst_end;
    logic                       frame_end;
    logic                       md_full;
    logic [ldp_pkg::data_w-1:0] md_beat0;
    logic [ldp_pkg::data_w-1:0] md_beat1;
    logic [31:0]                frames_started;

    ldp_ring_addr #(
        .burst_beats      (burst_beats),
        .bursts_per_group (bursts_per_group)
    ) u_ring_addr (
        .clk      (clk),
        .resetn   (resetn),
        .cfg      (cfg),
        .fd_step  (fd_step),
        .md_step  (md_step),
        .fd_addr  (fd_addr),
        .md0_addr (md0_addr),
        .md1_addr (md1_addr)
    );

    ldp_md_buffer u_md_buffer (
        .clk         (clk),
        .resetn      (resetn),
        .frame_start (frame_start),
        .md_data     (md_data),
        .md_valid    (md_valid),
        .md_ready    (md_ready),
        .md_full     (md_full),
        .md_beat0    (md_beat0),
        .md_beat1    (md_beat1)
    );

    ldp_beat_counter #(
        .burst_beats (burst_beats)
    ) u_beat_counter (
        .clk          (clk),
        .resetn       (resetn),
        .frame_bursts (cfg.frame_bursts),
        .beat_take    (beat_take),
        .burst_end    (burst_end),
        .frame_end    (frame_end)
    );

    // AW side follows the frame count published by the W side
    ldp_aw_sequencer #(
        .burst_beats (burst_beats)
    ) u_aw_sequencer (
        .clk            (clk),
        .resetn         (resetn),
        .cfg            (cfg),
        .frames_started (frames_started),
        .fd_addr        (fd_addr),
        .md0_addr       (md0_addr),
        .md1_addr       (md1_addr),
        .aw_ready       (aw_ready),
        .aw             (aw),
        .aw_valid       (aw_valid),
        .fd_step        (fd_step),
        .md_step        (md_step)
    );

    ldp_w_sequencer u_w_sequencer (
        .clk            (clk),
        .resetn         (resetn),
        .fd_data        (fd_data),
        .fd_valid       (fd_valid),
        .w_ready        (w_ready),
        .burst_end      (burst_end),
        .frame_end      (frame_end),
        .md_full        (md_full),
        .md_beat0       (md_beat0),
        .md_beat1       (md_beat1),
        .fd_ready       (fd_ready),
        .w              (w),
        .w_valid        (w_valid),
        .beat_take      (beat_take),
        .frame_start    (frame_start),
        .frames_started (frames_started)
    );

endmodule

//--- src/ldp_md_buffer.sv
// Metadata capture buffer
`timescale 1ns/1ps

module ldp_md_buffer (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          frame_start,
    input  logic [ldp_pkg::data_w-1:0]    md_data,
    input  logic                          md_valid,
    output logic                          md_ready,
    output logic                          md_full,
    output logic [ldp_pkg::data_w-1:0]    md_beat0,
    output logic [ldp_pkg::data_w-1:0]    md_beat1
);

    localparam int idx_w = $clog2(ldp_pkg::md_beats);

    logic                       armed;
    logic [idx_w-1:0]           idx;
    logic [ldp_pkg::data_w-1:0] held [ldp_pkg::md_beats];

    // Capture opens the cycle after the frame begins on W
    assign md_ready = armed;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            armed   <= 1'b0;
            idx     <= '0;
            md_full <= 1'b0;
        end else if (frame_start) begin
            armed   <= 1'b1;
            idx     <= '0;
            md_full <= 1'b0;
        end else if (md_valid && armed) begin
            idx <= idx + 1'b1;
            // The last beat closes the buffer until the next frame
            if (idx == idx_w'(ldp_pkg::md_beats - 1)) begin
                armed   <= 1'b0;
                md_full <= 1'b1;
            end
        end
    end

    // Beats stored in arrival order
    always_ff @(posedge clk) begin
        if (md_valid && armed) held[idx] <= md_data;
    end

    assign md_beat0 = held[0];
    assign md_beat1 = held[1];

endmodule

//--- src/ldp_pkg.sv
// Frame logger shared definitions
package ldp_pkg;

    // ============================================================
    // Bus widths
    // ============================================================

    // Width of the stream data and of the write data bus
    localparam int data_w = 64;

    // One strobe bit per data byte
    localparam int strb_w = data_w / 8;

    // Host address width
    localparam int addr_w = 64;

    // Each frame carries this many metadata beats
    localparam int md_beats = 2;

    // Bytes taken by one metadata copy in its ring
    localparam int md_bytes = md_beats * strb_w;

    // ============================================================
    // Grouped signals
    // ============================================================

    // Static configuration, held stable for the whole run
    typedef struct packed {
        logic [addr_w-1:0] fd0_base;
        logic [addr_w-1:0] fd1_base;
        logic [63:0]       fd_ring_size;
        logic [addr_w-1:0] md0_base;
        logic [addr_w-1:0] md1_base;
        logic [63:0]       md_ring_size;
        logic [addr_w-1:0] fc_addr;
        logic [31:0]       frame_bursts;
    } ldp_cfg_t;

    // One write request on the AW channel
    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [7:0]        len;
    } aw_req_t;

    // One beat on the W channel
    typedef struct packed {
        logic [data_w-1:0] data;
        logic [strb_w-1:0] strb;
        logic              last;
    } w_beat_t;

endpackage

//--- src/ldp_ring_addr.sv
// Ring buffer address pointers
`timescale 1ns/1ps

module ldp_ring_addr #(
    parameter int burst_beats      = 8,
    parameter int bursts_per_group = 4
) (
    input  logic                          clk,
    input  logic                          resetn,
    input  ldp_pkg::ldp_cfg_t             cfg,
    input  logic                          fd_step,
    input  logic                          md_step,
    output logic [ldp_pkg::addr_w-1:0]    fd_addr,
    output logic [ldp_pkg::addr_w-1:0]    md0_addr,
    output logic [ldp_pkg::addr_w-1:0]    md1_addr
);

    // Bytes covered by one frame-data burst
    localparam logic [63:0] fd_burst_bytes = 64'(burst_beats * ldp_pkg::strb_w);

    // The group counter runs over both rings, one group each
    localparam int grp_w = $clog2(2 * bursts_per_group);
    localparam logic [grp_w-1:0] grp_last = grp_w'(2 * bursts_per_group - 1);
    localparam logic [grp_w-1:0] grp_half = grp_w'(bursts_per_group);

    logic [63:0]      fd0_off;
    logic [63:0]      fd1_off;
    logic [63:0]      md_off;
    logic [grp_w-1:0] grp_cnt;
    logic             ring_sel;
    logic [63:0]      fd0_next;
    logic [63:0]      fd1_next;
    logic [63:0]      md_next;

    // Upper half of the group count selects ring 1
    assign ring_sel = (grp_cnt >= grp_half);

    // Next offsets, wrapping to zero at the ring size
    always_comb begin
        fd0_next = fd0_off + fd_burst_bytes;
        fd1_next = fd1_off + fd_burst_bytes;
        md_next  = md_off + 64'(ldp_pkg::md_bytes);
        if (fd0_next >= cfg.fd_ring_size) fd0_next = '0;
        if (fd1_next >= cfg.fd_ring_size) fd1_next = '0;
        if (md_next >= cfg.md_ring_size) md_next = '0;
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            fd0_off <= '0;
            fd1_off <= '0;
            md_off  <= '0;
            grp_cnt <= '0;
        end else begin
            if (fd_step) begin
                // Only the ring that took the burst moves on
                if (ring_sel) fd1_off <= fd1_next;
                else          fd0_off <= fd0_next;
                grp_cnt <= (grp_cnt == grp_last) ? '0 : grp_cnt + 1'b1;
            end
            // Both metadata copies share one offset
            if (md_step) md_off <= md_next;
        end
    end

    assign fd_addr  = ring_sel ? cfg.fd1_base + fd1_off : cfg.fd0_base + fd0_off;
    assign md0_addr = cfg.md0_base + md_off;
    assign md1_addr = cfg.md1_base + md_off;

endmodule

//--- src/ldp_w_sequencer.sv
// W channel data sequencer
`timescale 1ns/1ps

module ldp_w_sequencer (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic [ldp_pkg::data_w-1:0]    fd_data,
    input  logic                          fd_valid,
    input  logic                          w_ready,
    input  logic                          burst_end,
    input  logic                          frame_end,
    input  logic                          md_full,
    input  logic [ldp_pkg::data_w-1:0]    md_beat0,
    input  logic [ldp_pkg::data_w-1:0]    md_beat1,
    output logic                          fd_ready,
    output ldp_pkg::w_beat_t              w,
    output logic                          w_valid,
    output logic                          beat_take,
    output logic                          frame_start,
    output logic [31:0]                   frames_started
);

    typedef enum logic [2:0] {
        W_FD_FIRST,
        W_FD_REST,
        W_MD00,
        W_MD01,
        W_MD10,
        W_MD11,
        W_FC
    } w_state_t;

    w_state_t    state;
    logic [31:0] frame_cnt;
    logic        in_fd;
    logic        first_offer;
    logic        w_hs;

    assign in_fd       = (state == W_FD_FIRST) || (state == W_FD_REST);
    assign first_offer = (state == W_FD_FIRST) && fd_valid;
    assign w_hs        = w_valid && w_ready;

    // ============================================================
    // W channel mux
    // ============================================================
    always_comb begin
        fd_ready = 1'b0;
        w_valid  = md_full;
        w.data   = md_beat0;
        w.strb   = '1;
        w.last   = 1'b0;
        case (state)
            // Frame data passes straight through with no register
            W_FD_FIRST, W_FD_REST: begin
                fd_ready = w_ready;
                w_valid  = fd_valid;
                w.data   = fd_data;
                w.last   = burst_end;
            end
            W_MD00, W_MD10: w.data = md_beat0;
            W_MD01, W_MD11: begin
                w.data = md_beat1;
                w.last = 1'b1;
            end
            // Counter word is the frame number in both halves
            W_FC: begin
                w_valid = 1'b1;
                w.data  = {frame_cnt, frame_cnt};
                w.last  = 1'b1;
            end
            default: begin
                w_valid = 1'b0;
                w.strb  = '0;
            end
        endcase
    end

    assign beat_take   = in_fd && fd_valid && w_ready;
    assign frame_start = (state == W_FD_FIRST) && fd_valid && w_ready;

    // Counts the frame as soon as its first beat is offered, so AW can start alongside
    assign frames_started = frame_cnt + {31'd0, first_offer};

    // ============================================================
    // State transitions
    // ============================================================
    always_ff @(posedge clk) begin
        if (!resetn) begin
            state     <= W_FD_FIRST;
            frame_cnt <= '0;
        end else if (w_hs) begin
            case (state)
                W_FD_FIRST: begin
                    frame_cnt <= frame_cnt + 32'd1;
                    state     <= frame_end ? W_MD00 : W_FD_REST;
                end
                W_FD_REST: if (frame_end) state <= W_MD00;
                W_MD00:  state <= W_MD01;
                W_MD01:  state <= W_MD10;
                W_MD10:  state <= W_MD11;
                W_MD11:  state <= W_FC;
                default: state <= W_FD_FIRST;
            endcase
        end
    end

endmodule

//--- verification/ldp_props.sv
// Frame logger bus properties
`timescale 1ns/1ps

module ldp_props (
    input logic             clk,
    input logic             resetn,
    input ldp_pkg::aw_req_t aw,
    input logic             aw_valid,
    input logic             aw_ready,
    input ldp_pkg::w_beat_t w,
    input logic             w_valid,
    input logic             w_ready,
    input logic             fd_ready,
    input logic             md_ready
);

    // ============================================================
    // Handshake stability
    // ============================================================

    // An offered request stays up and unchanged until it is taken
    aw_hold: assert property (@(posedge clk) disable iff (!resetn)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw))
        else $error("AW request changed or dropped before aw_ready");

    w_hold: assert property (@(posedge clk) disable iff (!resetn)
        w_valid && !w_ready |=> w_valid && $stable(w))
        else $error("W beat changed or dropped before w_ready");

    // ============================================================
    // State after reset
    // ============================================================

    // Nothing is offered on AW or W right after reset
    reset_idle: assert property (@(posedge clk)
        !resetn |=> !aw_valid && !w_valid)
        else $error("AW or W offered right after reset");

    reset_md: assert property (@(posedge clk) !resetn |=> !md_ready)
        else $error("md_ready high right after reset");

    reset_fd: assert property (@(posedge clk) !resetn |=> !fd_ready)
        else $error("fd_ready high right after reset");

endmodule

bind ldp_manager ldp_props u_props (
    .clk      (clk),
    .resetn   (resetn),
    .aw       (aw),
    .aw_valid (aw_valid),
    .aw_ready (aw_ready),
    .w        (w),
    .w_valid  (w_valid),
    .w_ready  (w_ready),
    .fd_ready (fd_ready),
    .md_ready (md_ready)
);

//--- verification/ldp_tb.sv
// Frame logger testbench
`timescale 1ns/1ps

module ldp_tb;

    // ============================================================
    // Run configuration
    // ============================================================
    localparam int clk_period       = 8;
    localparam int burst_beats      = 8;
    localparam int bursts_per_group = 4;
    localparam int frame_bursts     = 6;
    localparam int fd_ring_bursts   = 5;
    localparam int md_ring_copies   = 3;
    localparam int md_copy_bytes    = 16;
    localparam int burst_bytes      = burst_beats * 8;
    localparam int n_frames         = 8;
    localparam int directed_frames  = 3;

    // Each frame is its data beats, two metadata copies of two beats and one counter word
    localparam int fd_per_frame = frame_bursts * burst_beats;
    localparam int w_per_frame  = fd_per_frame + 4 + 1;
    localparam int aw_per_frame = frame_bursts + 3;
    localparam int fd_total     = n_frames * fd_per_frame;
    localparam int md_total     = n_frames * 2;
    localparam int stall_margin = 8;
    localparam int watchdog_ns  = (10 + n_frames * w_per_frame * stall_margin) * clk_period;

    localparam logic [63:0] fd0_base = 64'h0000_0001_0000_0000;
    localparam logic [63:0] fd1_base = 64'h0000_0002_0000_0000;
    localparam logic [63:0] md0_base = 64'h0000_0003_0000_0000;
    localparam logic [63:0] md1_base = 64'h0000_0004_0000_0000;
    localparam logic [63:0] fc_addr  = 64'h0000_0005_0000_0000;

    logic              clk;
    logic              resetn;
    ldp_pkg::ldp_cfg_t cfg;
    logic [63:0]       fd_data;
    logic              fd_valid;
    logic              fd_ready;
    logic [63:0]       md_data;
    logic              md_valid;
    logic              md_ready;
    ldp_pkg::aw_req_t  aw;
    logic              aw_valid;
    logic              aw_ready;
    ldp_pkg::w_beat_t  w;
    logic              w_valid;
    logic              w_ready;

    // Scoreboard state shared by the driver and the comparing process
    logic [15:0]       lfsr;
    logic              stall_mode;
    logic              run;
    logic              fd_hs;
    logic              md_hs;
    int                fd_sent;
    int                md_sent;
    int                aw_count;
    int                w_count;
    int                checks;
    int                errors;
    logic [63:0]       fd_vals [fd_total];
    logic [63:0]       md_vals [md_total];
    ldp_pkg::aw_req_t  exp_aw;
    ldp_pkg::w_beat_t  exp_w;

    ldp_manager #(
        .burst_beats      (burst_beats),
        .bursts_per_group (bursts_per_group)
    ) uut (
        .clk      (clk),
        .resetn   (resetn),
        .cfg      (cfg),
        .fd_data  (fd_data),
        .fd_valid (fd_valid),
        .fd_ready (fd_ready),
        .md_data  (md_data),
        .md_valid (md_valid),
        .md_ready (md_ready),
        .aw       (aw),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .w        (w),
        .w_valid  (w_valid),
        .w_ready  (w_ready)
    );

    always #(clk_period / 2) clk = ~clk;

    // ============================================================
    // Random source and reporting helpers
    // ============================================================

    // Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [63:0] random_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic show_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        errors++;
        $display("error at %0t ns: %s is 0x%h, expected 0x%h", $time, name, got, exp);
    endtask

    task automatic show_failure(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    // ============================================================
    // Reference model of the host writes
    // ============================================================
    function automatic ldp_pkg::aw_req_t expected_aw(input int idx);
        ldp_pkg::aw_req_t req;
        int f;
        int r;
        int k;
        int j;
        logic [63:0] md_off;
        f = idx / aw_per_frame;
        r = idx % aw_per_frame;
        md_off = 64'((f * md_copy_bytes) % (md_ring_copies * md_copy_bytes));
        if (r < frame_bursts) begin
            // Global burst k lands in ring (k div 4) mod 2, as that ring's j-th burst
            k = f * frame_bursts + r;
            j = (k / (2 * bursts_per_group)) * bursts_per_group + k % bursts_per_group;
            req.addr = ((k / bursts_per_group) % 2 == 0) ? fd0_base : fd1_base;
            req.addr = req.addr + 64'((j % fd_ring_bursts) * burst_bytes);
            req.len  = 8'(burst_beats - 1);
        end else if (r == frame_bursts) begin
            req.addr = md0_base + md_off;
            req.len  = 8'd1;
        end else if (r == frame_bursts + 1) begin
            req.addr = md1_base + md_off;
            req.len  = 8'd1;
        end else begin
            req.addr = fc_addr;
            req.len  = 8'd0;
        end
        return req;
    endfunction

    function automatic ldp_pkg::w_beat_t expected_w(input int idx);
        ldp_pkg::w_beat_t beat;
        int f;
        int b;
        int m;
        f = idx / w_per_frame;
        b = idx % w_per_frame;
        beat.strb = '1;
        if (b < fd_per_frame) begin
            beat.data = fd_vals[f * fd_per_frame + b];
            beat.last = (b % burst_beats == burst_beats - 1);
        end else if (b < fd_per_frame + 4) begin
            // Two identical copies, each closing on its second beat
            m = b - fd_per_frame;
            beat.data = md_vals[2 * f + m % 2];
            beat.last = (m % 2 == 1);
        end else begin
            beat.data = {32'(f + 1), 32'(f + 1)};
            beat.last = 1'b1;
        end
        return beat;
    endfunction

    // ============================================================
    // Stimulus, driven 1 ns after each rising edge
    // ============================================================
    always @(posedge clk) begin
        run   = resetn;
        fd_hs = fd_valid && fd_ready;
        md_hs = md_valid && md_ready;
        #1;
        if (run) begin
            if (fd_hs) fd_sent++;
            if (md_hs) md_sent++;
            // A new beat may be offered only once the previous one is taken
            if (fd_hs || !fd_valid) begin
                fd_valid = 1'b0;
                if (fd_sent < fd_total && (!stall_mode || random_bits(2) != 0)) begin
                    fd_data = random_bits(64);
                    fd_vals[fd_sent] = fd_data;
                    fd_valid = 1'b1;
                end
            end
            // Under stalls each frame's metadata arrives only after all its frame data
            if (md_hs || !md_valid) begin
                md_valid = 1'b0;
                if (md_sent < md_total
                        && !(stall_mode && fd_sent < (md_sent / 2 + 1) * fd_per_frame)
                        && (!stall_mode || random_bits(2) != 0)) begin
                    md_data = random_bits(64);
                    md_vals[md_sent] = md_data;
                    md_valid = 1'b1;
                end
            end
            w_ready  = !stall_mode || random_bits(2) != 0;
            aw_ready = !stall_mode || random_bits(1) != 0;
        end
    end

    // ============================================================
    // Comparing process
    // ============================================================
    always @(posedge clk) begin
        if (resetn && aw_valid && aw_ready) begin
            assert (aw_count < n_frames * aw_per_frame)
                else show_failure("AW request issued after the last frame");
            exp_aw = expected_aw(aw_count);
            assert (aw.addr == exp_aw.addr)
                else show_mismatch("aw.addr", aw.addr, exp_aw.addr);
            assert (aw.len == exp_aw.len)
                else show_mismatch("aw.len", 64'(aw.len), 64'(exp_aw.len));
            aw_count++;
            checks++;
        end
        if (resetn && w_valid && w_ready) begin
            assert (w_count < n_frames * w_per_frame)
                else show_failure("W beat written after the last frame");
            if (w_count < n_frames * w_per_frame) begin
                exp_w = expected_w(w_count);
                assert (w.data == exp_w.data)
                    else show_mismatch("w.data", w.data, exp_w.data);
                assert (w.strb == exp_w.strb)
                    else show_mismatch("w.strb", 64'(w.strb), 64'(exp_w.strb));
                assert (w.last == exp_w.last)
                    else show_mismatch("w.last", 64'(w.last), 64'(exp_w.last));
            end
            w_count++;
            checks++;
        end
    end

    // Runs until both channels have finished the given number of frames
    task automatic run_test(input int num, input string name, input logic stalls,
                            input int frames);
        int errors_before;
        errors_before = errors;
        stall_mode = stalls;
        while (w_count < frames * w_per_frame || aw_count < frames * aw_per_frame)
            @(negedge clk);
        $display("test %0d %s: %0d frames done, %0d errors",
                 num, name, frames, errors - errors_before);
    endtask

    initial begin
        #(watchdog_ns);
        $display("timeout: frames not finished within %0d ns", watchdog_ns);
        $display("Regression failed");
        $finish;
    end

    initial begin
        clk        = 1'b0;
        resetn     = 1'b0;
        fd_data    = '0;
        fd_valid   = 1'b0;
        md_data    = '0;
        md_valid   = 1'b0;
        aw_ready   = 1'b0;
        w_ready    = 1'b0;
        lfsr       = 16'd9501;
        stall_mode = 1'b0;
        fd_sent    = 0;
        md_sent    = 0;
        aw_count   = 0;
        w_count    = 0;
        checks     = 0;
        errors     = 0;
        cfg.fd0_base     = fd0_base;
        cfg.fd1_base     = fd1_base;
        cfg.fd_ring_size = 64'(fd_ring_bursts * burst_bytes);
        cfg.md0_base     = md0_base;
        cfg.md1_base     = md1_base;
        cfg.md_ring_size = 64'(md_ring_copies * md_copy_bytes);
        cfg.fc_addr      = fc_addr;
        cfg.frame_bursts = 32'(frame_bursts);
        repeat (10) @(posedge clk);
        #1 resetn = 1'b1;
        run_test(1, "directed without stalls", 1'b0, directed_frames);
        run_test(2, "random stalls on all handshakes", 1'b1, n_frames);
        assert (fd_sent == fd_total) else show_failure("frame-data beats were not all taken");
        assert (md_sent == md_total) else show_failure("metadata beats were not all taken");
        assert (w_count == n_frames * w_per_frame)
            else show_failure("W beat count differs from the frames written");
        assert (aw_count == n_frames * aw_per_frame)
            else show_failure("AW request count differs from the frames written");
        $display("frames %0d, handshakes checked %0d, errors %0d", n_frames, checks, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule
